//--- Makefile
TOP = tb_butterfly

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): list.f *.sv
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f list.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f list.f --top-module butterfly_top

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

//--- bfly_control.sv
module bfly_control (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   in_valid,
	input  bfly_pkg::twiddle_op_t  op,
	input  logic                   out_ready,
	output logic                   in_ready,
	output logic                   out_valid,
	output logic                   load,
	output logic                   mul_clear,
	output logic                   mul_step,
	output logic                   mul_last,
	output bfly_pkg::mul_phase_t   phase,
	output logic                   prod_capture,
	output logic                   result_load,
	output bfly_pkg::twiddle_op_t  op_q
);
	import bfly_pkg::*;
	import fxp_pkg::*;

	bfly_state_t state;
	logic [step_bits-1:0] cnt;
	logic stepping; // low during the operand clear cycle
	logic finish;   // products ready, next cycle loads the result

	assign in_ready = (state == st_idle);
	assign out_valid = (state == st_done);
	assign load = in_valid & in_ready;

	assign mul_clear = (state == st_mul) & ~finish & ~stepping;
	assign mul_step = (state == st_mul) & ~finish & stepping;
	assign mul_last = mul_step & (cnt == step_bits'(width - 1));
	// multiplier exposes its next value, so capture lines up with the last step
	assign prod_capture = mul_last;
	assign result_load = (state == st_mul) & finish;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			phase <= ph_sum;
			cnt <= '0;
			stepping <= 1'b0;
			finish <= 1'b0;
			op_q <= tw_general;
		end else begin
			case (state)
				st_idle: begin
					if (load) begin
						state <= st_mul;
						op_q <= op;
						phase <= ph_sum;
						cnt <= '0;
						stepping <= 1'b0;
						finish <= (op != tw_general); // trivial ops go straight to result
					end
				end
				st_mul: begin
					if (finish) begin
						state <= st_done;
						finish <= 1'b0;
					end else if (!stepping) begin
						stepping <= 1'b1;
						cnt <= '0;
					end else if (mul_last) begin
						stepping <= 1'b0;
						cnt <= '0;
						if (phase == ph_imag)
							finish <= 1'b1;
						else
							phase <= (phase == ph_sum) ? ph_real : ph_imag;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_done: begin
					if (out_ready)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

//--- bfly_pkg.sv
package bfly_pkg;

	// twiddle selection, trivial ones skip the multiplier
	typedef enum logic [2:0] {
		tw_general,
		tw_one,
		tw_minus_one,
		tw_plus_j,
		tw_minus_j
	} twiddle_op_t;

	// which of the three partial products is being formed
	typedef enum logic [1:0] {
		ph_sum,
		ph_real,
		ph_imag
	} mul_phase_t;

	typedef enum logic [1:0] {
		st_idle,
		st_mul,
		st_done
	} bfly_state_t;

endpackage

//--- butterfly_combine.sv
module butterfly_combine (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  load,
	input  fxp_pkg::fxp_t         a_re,
	input  fxp_pkg::fxp_t         a_im,
	input  bfly_pkg::twiddle_op_t op_q,
	input  fxp_pkg::fxp_t         t_re,
	input  fxp_pkg::fxp_t         t_im,
	input  fxp_pkg::fxp_t         b_re_q,
	input  fxp_pkg::fxp_t         b_im_q,
	input  logic                  result_load,
	output fxp_pkg::fxp_t         c_re,
	output fxp_pkg::fxp_t         c_im,
	output fxp_pkg::fxp_t         d_re,
	output fxp_pkg::fxp_t         d_im
);
	import fxp_pkg::*;
	import bfly_pkg::*;

	fxp_t a_re_q;
	fxp_t a_im_q;
	fxp_t sel_re;
	fxp_t sel_im;

	always_ff @(posedge clk) begin
		if (load) begin
			a_re_q <= a_re;
			a_im_q <= a_im;
		end
	end

	// w*b, trivial twiddles are just sign and swap of b
	always_comb begin
		case (op_q)
			tw_one: begin
				sel_re = b_re_q;
				sel_im = b_im_q;
			end
			tw_minus_one: begin
				sel_re = -b_re_q;
				sel_im = -b_im_q;
			end
			tw_plus_j: begin
				sel_re = -b_im_q;
				sel_im = b_re_q;
			end
			tw_minus_j: begin
				sel_re = b_im_q;
				sel_im = -b_re_q;
			end
			default: begin
				sel_re = t_re;
				sel_im = t_im;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			c_re <= '0;
			c_im <= '0;
			d_re <= '0;
			d_im <= '0;
		end else if (result_load) begin
			c_re <= a_re_q + sel_re;
			c_im <= a_im_q + sel_im;
			d_re <= a_re_q - sel_re;
			d_im <= a_im_q - sel_im;
		end
	end

endmodule

//--- butterfly_top.sv
module butterfly_top (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  in_valid,
	input  bfly_pkg::twiddle_op_t op,
	input  fxp_pkg::fxp_t         a_re,
	input  fxp_pkg::fxp_t         a_im,
	input  fxp_pkg::fxp_t         b_re,
	input  fxp_pkg::fxp_t         b_im,
	input  fxp_pkg::fxp_t         w_re,
	input  fxp_pkg::fxp_t         w_im,
	input  logic                  out_ready,
	output logic                  in_ready,
	output logic                  out_valid,
	output fxp_pkg::fxp_t         c_re,
	output fxp_pkg::fxp_t         c_im,
	output fxp_pkg::fxp_t         d_re,
	output fxp_pkg::fxp_t         d_im
);
	import fxp_pkg::*;
	import bfly_pkg::*;

	logic load;
	logic mul_clear;
	logic mul_step;
	logic mul_last;
	logic prod_capture;
	logic result_load;
	mul_phase_t phase;
	twiddle_op_t op_q;
	fxp_t mul_a;
	fxp_t mul_b;
	fxp_t product;
	fxp_t t_re;
	fxp_t t_im;
	fxp_t b_re_q;
	fxp_t b_im_q;

	bfly_control control_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.op(op),
		.out_ready(out_ready),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.load(load),
		.mul_clear(mul_clear),
		.mul_step(mul_step),
		.mul_last(mul_last),
		.phase(phase),
		.prod_capture(prod_capture),
		.result_load(result_load),
		.op_q(op_q)
	);

	shift_add_multiplier mult_i (
		.clk(clk),
		.reset(reset),
		.mul_clear(mul_clear),
		.mul_step(mul_step),
		.mul_last(mul_last),
		.mul_a(mul_a),
		.mul_b(mul_b),
		.product(product)
	);

	twiddle_product twiddle_i (
		.clk(clk),
		.reset(reset),
		.load(load),
		.b_re(b_re),
		.b_im(b_im),
		.w_re(w_re),
		.w_im(w_im),
		.phase(phase),
		.prod_capture(prod_capture),
		.product(product),
		.mul_a(mul_a),
		.mul_b(mul_b),
		.t_re(t_re),
		.t_im(t_im),
		.b_re_q(b_re_q),
		.b_im_q(b_im_q)
	);

	butterfly_combine combine_i (
		.clk(clk),
		.reset(reset),
		.load(load),
		.a_re(a_re),
		.a_im(a_im),
		.op_q(op_q),
		.t_re(t_re),
		.t_im(t_im),
		.b_re_q(b_re_q),
		.b_im_q(b_im_q),
		.result_load(result_load),
		.c_re(c_re),
		.c_im(c_im),
		.d_re(d_re),
		.d_im(d_im)
	);

endmodule

//--- fxp_pkg.sv
package fxp_pkg;

	// Q8.8 samples, two's complement
	localparam int width = 16;
	localparam int frac_bits = 8;

	// counts the width steps of one multiply
	localparam int step_bits = 4;

	typedef logic signed [width-1:0] fxp_t;

endpackage

//--- list.f
fxp_pkg.sv
bfly_pkg.sv
bfly_control.sv
shift_add_multiplier.sv
twiddle_product.sv
butterfly_combine.sv
butterfly_top.sv
tb_butterfly.sv

//--- shift_add_multiplier.sv
module shift_add_multiplier (
	input  logic          clk,
	input  logic          reset,
	input  logic          mul_clear,
	input  logic          mul_step,
	input  logic          mul_last,
	input  fxp_pkg::fxp_t mul_a,
	input  fxp_pkg::fxp_t mul_b,
	output fxp_pkg::fxp_t product
);
	import fxp_pkg::*;

	logic [2*width-1:0] mcand; // shifts left each step
	logic [width-1:0] mplier;  // shifts right each step
	logic [2*width-1:0] acc;
	logic [2*width-1:0] acc_d;

	// next accumulator value
	// sign bit of the multiplier carries weight -2^(width-1), hence subtract on last
	always_comb begin
		acc_d = acc;
		if (mul_clear)
			acc_d = '0;
		else if (mul_step && mplier[0])
			acc_d = mul_last ? acc - mcand : acc + mcand;
	end

	assign product = fxp_t'(acc_d[frac_bits +: width]);

	always_ff @(posedge clk) begin
		if (reset)
			acc <= '0;
		else
			acc <= acc_d;
	end

	always_ff @(posedge clk) begin
		if (mul_clear) begin
			mcand <= {{width{mul_a[width-1]}}, mul_a}; // sign extend
			mplier <= mul_b;
		end else if (mul_step) begin
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

endmodule

//--- tb_butterfly.sv
module tb_butterfly;
	timeunit 1ns;
	timeprecision 1ps;

	import fxp_pkg::*;
	import bfly_pkg::*;

	typedef struct packed {
		twiddle_op_t op;
		fxp_t a_re;
		fxp_t a_im;
		fxp_t b_re;
		fxp_t b_im;
		fxp_t w_re;
		fxp_t w_im;
		fxp_t c_re;
		fxp_t c_im;
		fxp_t d_re;
		fxp_t d_im;
	} vec_t;

	localparam int num_table = 14;
	localparam int num_random = 40;
	localparam int general_latency = 3 * (width + 1) + 1;
	localparam int timeout_cycles = 2 * (num_table + num_random) * (3 * (width + 1) + 6);

	logic clk;
	logic reset;
	logic in_valid;
	twiddle_op_t op;
	fxp_t a_re;
	fxp_t a_im;
	fxp_t b_re;
	fxp_t b_im;
	fxp_t w_re;
	fxp_t w_im;
	logic out_ready;
	logic in_ready;
	logic out_valid;
	fxp_t c_re;
	fxp_t c_im;
	fxp_t d_re;
	fxp_t d_im;

	vec_t vectors [num_table];
	int cycle_count = 0;
	int vec_index = 0;

	butterfly_top dut_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.op(op),
		.a_re(a_re),
		.a_im(a_im),
		.b_re(b_re),
		.b_im(b_im),
		.w_re(w_re),
		.w_im(w_im),
		.out_ready(out_ready),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.c_re(c_re),
		.c_im(c_im),
		.d_re(d_re),
		.d_im(d_im)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("TEST FAILED");
			$fatal(1, "timeout, the run did not finish within %0d cycles", timeout_cycles);
		end
	end

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h in vector %0d", name, got, exp, vec_index);
			$display("TEST FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// Q8.8 multiply, middle bits of the exact product
	function automatic fxp_t fixed_mul(fxp_t x, fxp_t y);
		logic signed [2*width-1:0] full;
		full = $signed({{width{x[width-1]}}, x}) * $signed({{width{y[width-1]}}, y});
		return full[frac_bits +: width];
	endfunction

	function automatic vec_t make_vec(twiddle_op_t o, fxp_t ar, fxp_t ai, fxp_t br,
			fxp_t bi, fxp_t wr, fxp_t wi);
		vec_t v;
		fxp_t t_re;
		fxp_t t_im;
		fxp_t k_sum;
		fxp_t k_re;
		fxp_t k_im;
		v = '0;
		v.op = o;
		v.a_re = ar;
		v.a_im = ai;
		v.b_re = br;
		v.b_im = bi;
		v.w_re = wr;
		v.w_im = wi;
		case (o)
			tw_one: begin
				t_re = br;
				t_im = bi;
			end
			tw_minus_one: begin
				t_re = -br;
				t_im = -bi;
			end
			tw_plus_j: begin
				t_re = -bi;
				t_im = br;
			end
			tw_minus_j: begin
				t_re = bi;
				t_im = -br;
			end
			default: begin
				k_sum = fixed_mul(fxp_t'(br + bi), fxp_t'(wr + wi));
				k_re = fixed_mul(br, wr);
				k_im = fixed_mul(bi, wi);
				t_re = k_re - k_im;
				t_im = k_sum - k_re - k_im;
			end
		endcase
		v.c_re = ar + t_re;
		v.c_im = ai + t_im;
		v.d_re = ar - t_re;
		v.d_im = ai - t_im;
		return v;
	endfunction

	task automatic check_outputs(input vec_t v);
		check_value("c_re", c_re, v.c_re);
		check_value("c_im", c_im, v.c_im);
		check_value("d_re", d_re, v.d_re);
		check_value("d_im", d_im, v.d_im);
	endtask

	task automatic send_input(input vec_t v);
		@(negedge clk);
		op = v.op;
		a_re = v.a_re;
		a_im = v.a_im;
		b_re = v.b_re;
		b_im = v.b_im;
		w_re = v.w_re;
		w_im = v.w_im;
		in_valid = 1'b1;
		while (in_ready !== 1'b1)
			@(negedge clk);
		@(negedge clk); // accepted on the edge in between
		in_valid = 1'b0;
		check_value("in_ready", 16'(in_ready), 16'h0);
	endtask

	task automatic collect_output(input vec_t v, input int hold);
		int lat;
		lat = 0;
		while (out_valid !== 1'b1) begin
			@(negedge clk);
			lat++;
		end
		check_value("latency", 16'(lat), 16'((v.op == tw_general) ? general_latency : 1));
		check_outputs(v);
		repeat (hold) begin
			@(negedge clk);
			check_value("out_valid", 16'(out_valid), 16'h1);
			check_value("in_ready", 16'(in_ready), 16'h0);
			check_outputs(v); // held under back-pressure
		end
		out_ready = 1'b1;
		@(negedge clk);
		out_ready = 1'b0;
		check_value("out_valid", 16'(out_valid), 16'h0);
		check_value("in_ready", 16'(in_ready), 16'h1);
	endtask

	task automatic apply_vector(input vec_t v, input int hold);
		send_input(v);
		collect_output(v, hold);
	endtask

	initial begin
		void'($urandom(49097));
		clk = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		op = tw_general;
		a_re = '0;
		a_im = '0;
		b_re = '0;
		b_im = '0;
		w_re = '0;
		w_im = '0;
		out_ready = 1'b0;
		repeat (16) @(negedge clk);
		reset = 1'b0;

		check_value("in_ready", 16'(in_ready), 16'h1);
		check_value("out_valid", 16'(out_valid), 16'h0);
		check_value("c_re", c_re, 16'h0);
		check_value("c_im", c_im, 16'h0);
		check_value("d_re", d_re, 16'h0);
		check_value("d_im", d_im, 16'h0);

		// trivial twiddles, w ignored
		vectors[0] = make_vec(tw_one, 16'h0100, 16'h0200, 16'h0080, 16'hff00, 16'h5a5a, 16'h5a5a);
		vectors[1] = make_vec(tw_one, 16'h7fff, 16'h8000, 16'h0001, 16'hffff, 16'h1234, 16'h4321);
		vectors[2] = make_vec(tw_minus_one, 16'h0300, 16'hfd00, 16'h0140, 16'h0020,
			16'h0000, 16'h0000);
		vectors[3] = make_vec(tw_minus_one, 16'h0000, 16'h0001, 16'h8000, 16'h8000,
			16'hffff, 16'hffff);
		vectors[4] = make_vec(tw_plus_j, 16'h0100, 16'h0100, 16'h0200, 16'hff80, 16'h0100, 16'h0);
		vectors[5] = make_vec(tw_plus_j, 16'h7fff, 16'h7fff, 16'h7fff, 16'h8000, 16'h0, 16'h0);
		vectors[6] = make_vec(tw_minus_j, 16'hff00, 16'h0040, 16'h0010, 16'h0300,
			16'h0a0a, 16'h0b0b);
		vectors[7] = make_vec(tw_minus_j, 16'h8000, 16'h8000, 16'h8000, 16'h7fff, 16'h0, 16'h0);
		// general twiddles
		vectors[8] = make_vec(tw_general, 16'h0100, 16'h0200, 16'h0180, 16'hff40,
			16'h0100, 16'h0000);
		vectors[9] = make_vec(tw_general, 16'h0040, 16'hffc0, 16'h0100, 16'h0100,
			16'h00b5, 16'hff4b); // 45 degrees
		vectors[10] = make_vec(tw_general, 16'h1234, 16'hedcc, 16'hfe80, 16'h0280,
			16'hff4b, 16'hff4b);
		vectors[11] = make_vec(tw_general, 16'hfff0, 16'h0010, 16'h00c0, 16'hff20,
			16'h0000, 16'hff00);
		vectors[12] = make_vec(tw_general, 16'h0001, 16'hffff, 16'h7fff, 16'h8000,
			16'h7fff, 16'h7fff); // extremes
		vectors[13] = make_vec(tw_general, 16'h0010, 16'h0020, 16'h8000, 16'h0001,
			16'h0001, 16'h8000);

		for (int i = 0; i < num_table; i++) begin
			vec_index = i;
			apply_vector(vectors[i], $urandom_range(6, 0));
		end

		for (int i = 0; i < num_random; i++) begin
			vec_index = num_table + i;
			apply_vector(make_vec(tw_general, fxp_t'($urandom()), fxp_t'($urandom()),
				fxp_t'($urandom()), fxp_t'($urandom()), fxp_t'($urandom()),
				fxp_t'($urandom())), $urandom_range(6, 0));
		end

		$display("TEST OK");
		$finish;
	end

endmodule

//--- twiddle_product.sv
module twiddle_product (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 load,
	input  fxp_pkg::fxp_t        b_re,
	input  fxp_pkg::fxp_t        b_im,
	input  fxp_pkg::fxp_t        w_re,
	input  fxp_pkg::fxp_t        w_im,
	input  bfly_pkg::mul_phase_t phase,
	input  logic                 prod_capture,
	input  fxp_pkg::fxp_t        product,
	output fxp_pkg::fxp_t        mul_a,
	output fxp_pkg::fxp_t        mul_b,
	output fxp_pkg::fxp_t        t_re,
	output fxp_pkg::fxp_t        t_im,
	output fxp_pkg::fxp_t        b_re_q,
	output fxp_pkg::fxp_t        b_im_q
);
	import fxp_pkg::*;
	import bfly_pkg::*;

	fxp_t w_re_q;
	fxp_t w_im_q;
	fxp_t k_sum;
	fxp_t k_re;
	fxp_t k_im;

	always_ff @(posedge clk) begin
		if (load) begin
			b_re_q <= b_re;
			b_im_q <= b_im;
			w_re_q <= w_re;
			w_im_q <= w_im;
		end
	end

	// operand pair for the current phase, sums wrap
	always_comb begin
		case (phase)
			ph_sum: begin
				mul_a = b_re_q + b_im_q;
				mul_b = w_re_q + w_im_q;
			end
			ph_real: begin
				mul_a = b_re_q;
				mul_b = w_re_q;
			end
			default: begin
				mul_a = b_im_q;
				mul_b = w_im_q;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			k_sum <= '0;
			k_re <= '0;
			k_im <= '0;
		end else if (prod_capture) begin
			case (phase)
				ph_sum:  k_sum <= product;
				ph_real: k_re <= product;
				default: k_im <= product;
			endcase
		end
	end

	// three-multiply complex product
	assign t_re = k_re - k_im;
	assign t_im = k_sum - k_re - k_im;

endmodule
